// ==== list.f ====
+incdir+.
ccuIsaPkg.sv
ccuCfgPkg.sv
isaDecoder.sv
isaCollector.sv
ccuTop.sv
ccuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CCU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module ccuTb -o ccuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/ccuSim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "Simulation output has no pass line"
exit 1

// ==== ccuTbModel.svh ====
/*
 * Reference model for the CCU testbench, included in the testbench module.
 * Random generator, expected configuration queues built from the words of
 * each issued instruction, and one compare task per result type.
 */
`ifndef CCU_TB_MODEL_SVH
`define CCU_TB_MODEL_SVH

// Generator states, one for the instruction stream and one for the engines
logic [31:0] stimRand = 32'h2244;
logic [31:0] engRand  = 32'h2244;

// Expected configurations in issue order
knnCfgT knnExpQ[$];
syaCfgT syaExpQ[$];
gicCfgT gicExpQ[$];

function automatic logic [31:0] nextRand(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
endfunction

function automatic isaWordT randWord();
    return {nextRand(stimRand), nextRand(stimRand),
            nextRand(stimRand), nextRand(stimRand)};
endfunction

task automatic failRun(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on first failure");
endtask

// ==============================
// Compare tasks
// ==============================
task automatic checkFlag(input logic act, input logic expVal, input string what);
    if (act !== expVal) begin
        failRun($sformatf("Error at %0t: %s is %b, expected %b", $time, what, act, expVal));
    end
endtask

task automatic checkKnn(input knnCfgT act, input knnCfgT expVal, input string what);
    if (act !== expVal) begin
        failRun($sformatf("Error at %0t: %s got %h expected %h", $time, what, act, expVal));
    end
endtask

task automatic checkSya(input syaCfgT act, input syaCfgT expVal, input string what);
    if (act !== expVal) begin
        failRun($sformatf("Error at %0t: %s got %h expected %h", $time, what, act, expVal));
    end
endtask

task automatic checkGic(input gicCfgT act, input gicCfgT expVal, input string what);
    if (act !== expVal) begin
        failRun($sformatf("Error at %0t: %s got %h expected %h", $time, what, act, expVal));
    end
endtask

// ==============================
// Expected structs from raw words
// ==============================
// Word 0 sits in the low bits, opcode in raw[7:0]
function automatic knnCfgT expectKnn(input logic [2*WordBits-1:0] raw);
    knnCfgT c;
    c.nip       = raw[23:8];
    c.k         = raw[31:24];
    c.crdRdAddr = raw[47:32];
    c.mapWrAddr = raw[63:48];
    c.rsv       = raw[255:64];
    return c;
endfunction

function automatic syaCfgT expectSya(input logic [3*WordBits-1:0] raw);
    syaCfgT c;
    c.mode          = raw[15:8];
    c.ofmPhaseShift = raw[23:16];
    c.shift         = raw[31:24];
    c.zp            = raw[39:32];
    c.chn           = raw[55:40];
    c.numGrpPerTile = raw[71:56];
    c.numTilFlt     = raw[87:72];
    c.numTilIfm     = raw[103:88];
    c.loopOrder     = raw[111:104];
    c.actRdBaseAddr = raw[127:112];   // Ends exactly at the word boundary
    c.wgtRdBaseAddr = raw[143:128];
    c.ofmWrBaseAddr = raw[159:144];
    c.rsv           = raw[383:160];
    return c;
endfunction

function automatic gicCfgT expectGic(input logic [2*WordBits-1:0] raw);
    gicCfgT c;
    c.inOut        = raw[15:8];
    c.dramBaseAddr = raw[47:16];
    c.glbBaseAddr  = raw[63:48];
    c.num          = raw[79:64];
    c.rsv          = raw[255:80];
    return c;
endfunction

`endif

// ==== ccuTb.sv ====
/*
 * Testbench for the configuration control unit. Sends random instructions
 * with random gaps, applies random engine back-pressure and checks each
 * delivered configuration against the reference model.
 */
module ccuTb;
    import ccuIsaPkg::*;
    import ccuCfgPkg::*;

    localparam int NumInstr    = 300;
    localparam int ClkPeriod   = 8;
    localparam int WatchCycles = NumInstr * 3 * 40;   // Up to 3 words per instruction
    localparam int DrainCycles = 500;

    logic    clk = 1'b0;
    logic    rst_n;
    isaWordT isaWord;
    logic    isaVld;
    logic    isaRdy;
    knnCfgT  knnCfg;
    logic    knnCfgVld;
    logic    knnCfgRdy;
    syaCfgT  syaCfg;
    logic    syaCfgVld;
    logic    syaCfgRdy;
    gicCfgT  gicCfg;
    logic    gicCfgVld;
    logic    gicCfgRdy;

    // Engine side state
    logic    knnHeld = 1'b0;
    logic    syaHeld = 1'b0;
    logic    gicHeld = 1'b0;
    knnCfgT  knnHeldCfg;
    syaCfgT  syaHeldCfg;
    gicCfgT  gicHeldCfg;

    `include "ccuTbModel.svh"

    always #(ClkPeriod / 2) clk = ~clk;

    ccuTop dut0 (.*);

    // Configurations still owed by the DUT
    function automatic int pendingCfgs();
        return knnExpQ.size() + syaExpQ.size() + gicExpQ.size();
    endfunction

    task automatic checkIdle(input string when);
        checkFlag(isaRdy, 1'b0, {"isaRdy ", when});
        checkFlag(knnCfgVld, 1'b0, {"knnCfgVld ", when});
        checkFlag(syaCfgVld, 1'b0, {"syaCfgVld ", when});
        checkFlag(gicCfgVld, 1'b0, {"gicCfgVld ", when});
    endtask

    // ==============================
    // Instruction stream
    // ==============================
    task automatic sendWord(input isaWordT w);
        logic taken;
        taken = 1'b0;
        repeat ((nextRand(stimRand) >> 16) % 3) begin
            isaVld = 1'b0;
            @(negedge clk);
        end
        isaVld  = 1'b1;
        isaWord = w;
        while (!taken) begin
            taken = isaRdy;                   // isaRdy only moves on posedge
            @(negedge clk);
        end
    endtask

    task automatic sendInstr();
        logic [31:0] pick;
        isaWordT     w0;
        isaWordT     w1;
        isaWordT     w2;
        pick = nextRand(stimRand) >> 16;
        w0   = randWord();
        w1   = randWord();
        w2   = randWord();
        case (pick % 10)
            0, 1, 2: begin
                w0[7:0] = OpKnn;
                knnExpQ.push_back(expectKnn({w1, w0}));
                sendWord(w0);
                sendWord(w1);
            end
            3, 4, 5: begin
                w0[7:0] = OpSya;
                syaExpQ.push_back(expectSya({w2, w1, w0}));
                sendWord(w0);
                sendWord(w1);
                sendWord(w2);
            end
            6, 7, 8: begin
                w0[7:0]  = OpGic;
                w0[15:8] = w0[8] ? GicOut2Mem : GicIn2Chip;
                gicExpQ.push_back(expectGic({w1, w0}));
                sendWord(w0);
                sendWord(w1);
            end
            default: begin
                if (w0[7:0] inside {OpKnn, OpSya, OpGic}) begin
                    w0[7] = 1'b1;             // Force an unknown code
                end
                sendWord(w0);
            end
        endcase
    endtask

    initial begin
        rst_n     = 1'b0;
        isaVld    = 1'b0;
        isaWord   = '0;
        knnCfgRdy = 1'b0;
        syaCfgRdy = 1'b0;
        gicCfgRdy = 1'b0;
        repeat (5) begin
            @(negedge clk);
            checkIdle("during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        checkIdle("after reset");
        repeat (NumInstr) begin
            sendInstr();
        end
        isaVld = 1'b0;
        for (int n = 0; n < DrainCycles && pendingCfgs() != 0; n++) begin
            @(negedge clk);
        end
        if (pendingCfgs() != 0) begin
            failRun($sformatf("%0d configurations were never delivered", pendingCfgs()));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    initial begin
        #(WatchCycles * ClkPeriod);
        failRun("The run timed out before all instructions were delivered");
    end

    // ==============================
    // Engines with random ready
    // ==============================
    always @(negedge clk) begin
        if (knnHeld) begin
            checkFlag(knnCfgVld, 1'b1, "knnCfgVld under back-pressure");
            checkKnn(knnCfg, knnHeldCfg, "held knnCfg");
        end
        knnCfgRdy = ((nextRand(engRand) >> 16) % 3) != 0;
        if (knnCfgVld && knnCfgRdy) begin
            if (knnExpQ.size() == 0) begin
                failRun("A KNN configuration appeared with no KNN instruction pending");
            end else begin
                checkKnn(knnCfg, knnExpQ.pop_front(), "knnCfg");
            end
        end
        knnHeld    = knnCfgVld && !knnCfgRdy;
        knnHeldCfg = knnCfg;

        if (syaHeld) begin
            checkFlag(syaCfgVld, 1'b1, "syaCfgVld under back-pressure");
            checkSya(syaCfg, syaHeldCfg, "held syaCfg");
        end
        syaCfgRdy = ((nextRand(engRand) >> 16) % 3) != 0;
        if (syaCfgVld && syaCfgRdy) begin
            if (syaExpQ.size() == 0) begin
                failRun("An SYA configuration appeared with no SYA instruction pending");
            end else begin
                checkSya(syaCfg, syaExpQ.pop_front(), "syaCfg");
            end
        end
        syaHeld    = syaCfgVld && !syaCfgRdy;
        syaHeldCfg = syaCfg;

        if (gicHeld) begin
            checkFlag(gicCfgVld, 1'b1, "gicCfgVld under back-pressure");
            checkGic(gicCfg, gicHeldCfg, "held gicCfg");
        end
        gicCfgRdy = ((nextRand(engRand) >> 16) % 3) != 0;
        if (gicCfgVld && gicCfgRdy) begin
            if (gicExpQ.size() == 0) begin
                failRun("A GIC configuration appeared with no GIC instruction pending");
            end else begin
                checkGic(gicCfg, gicExpQ.pop_front(), "gicCfg");
            end
        end
        gicHeld    = gicCfgVld && !gicCfgRdy;
        gicHeldCfg = gicCfg;
    end

endmodule

// ==== ccuTop.sv ====
/*
 * Configuration control unit top level. The decoder reads the instruction
 * stream and feeds one collector per engine; each engine pulls its
 * configuration through its own valid/ready port.
 */
module ccuTop (
    input  logic               clk,
    input  logic               rst_n,

    // Instruction stream
    input  ccuIsaPkg::isaWordT isaWord,
    input  logic               isaVld,
    output logic               isaRdy,

    // Neighbour search engine
    output ccuCfgPkg::knnCfgT  knnCfg,
    output logic               knnCfgVld,
    input  logic               knnCfgRdy,

    // Systolic array
    output ccuCfgPkg::syaCfgT  syaCfg,
    output logic               syaCfgVld,
    input  logic               syaCfgRdy,

    // Off-chip transfer interface
    output ccuCfgPkg::gicCfgT  gicCfg,
    output logic               gicCfgVld,
    input  logic               gicCfgRdy
);
    import ccuIsaPkg::*;
    import ccuCfgPkg::*;

    isaBeatT   beat;
    engineVecT beatVld;
    engineVecT collRdy;

    // ==============================
    // Decoder
    // ==============================
    isaDecoder decoder0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .isaWord (isaWord),
        .isaVld  (isaVld),
        .isaRdy  (isaRdy),
        .beat    (beat),
        .beatVld (beatVld),
        .collRdy (collRdy)
    );

    // ==============================
    // Collectors, one per engine
    // ==============================
    isaCollector #(
        .PayloadT (knnCfgT)
    ) knnColl (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat    (beat),
        .beatVld (beatVld[EngKnn]),
        .beatRdy (collRdy[EngKnn]),
        .cfg     (knnCfg),
        .cfgVld  (knnCfgVld),
        .cfgRdy  (knnCfgRdy)
    );

    isaCollector #(
        .PayloadT (syaCfgT)
    ) syaColl (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat    (beat),
        .beatVld (beatVld[EngSya]),
        .beatRdy (collRdy[EngSya]),
        .cfg     (syaCfg),
        .cfgVld  (syaCfgVld),
        .cfgRdy  (syaCfgRdy)
    );

    isaCollector #(
        .PayloadT (gicCfgT)
    ) gicColl (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat    (beat),
        .beatVld (beatVld[EngGic]),
        .beatRdy (collRdy[EngGic]),
        .cfg     (gicCfg),
        .cfgVld  (gicCfgVld),
        .cfgRdy  (gicCfgRdy)
    );

endmodule

// ==== isaCollector.sv ====
/*
 * Instruction collector for one engine. Shifts in the words of one
 * instruction and presents them above the opcode byte as PayloadT, held
 * under valid/ready until the engine takes them.
 */
module isaCollector #(
    parameter type PayloadT = ccuIsaPkg::isaWordT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ccuIsaPkg::isaBeatT beat,
    input  logic               beatVld,
    output logic               beatRdy,
    output PayloadT            cfg,
    output logic               cfgVld,
    input  logic               cfgRdy
);
    import ccuIsaPkg::*;

    // Buffer rounded up to whole words
    localparam int PayBits  = $bits(PayloadT);
    localparam int BufWords = (PayBits + OpcodeBits + WordBits - 1) / WordBits;
    localparam int BufBits  = BufWords * WordBits;

    logic [BufBits-1:0]          shiftBuf;
    logic [BufBits+WordBits-1:0] shiftIn;
    logic                        beatXfer;

    assign beatRdy  = !cfgVld;                // Busy while a config is held
    assign beatXfer = beatVld && beatRdy;

    // New word enters at the top, first word ends at the bottom
    assign shiftIn = {beat.word, shiftBuf};

    // ==============================
    // Word buffer
    // ==============================
    always_ff @(posedge clk) begin
        if (beatXfer) begin
            shiftBuf <= shiftIn[BufBits+WordBits-1 -: BufBits];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfgVld <= 1'b0;
        end else if (cfgVld) begin
            if (cfgRdy) begin
                cfgVld <= 1'b0;               // Engine took it
            end
        end else if (beatXfer && beat.last) begin
            cfgVld <= 1'b1;
        end
    end

    // Opcode byte stays behind
    assign cfg = shiftBuf[OpcodeBits +: PayBits];

endmodule

// ==== isaDecoder.sv ====
/*
 * Instruction decoder. Captures the opcode of each new instruction, counts
 * its words and steers them to the collector of the target engine.
 * Unknown opcodes are one word long and are dropped.
 */
module isaDecoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ccuIsaPkg::isaWordT   isaWord,
    input  logic                 isaVld,
    output logic                 isaRdy,
    output ccuIsaPkg::isaBeatT   beat,
    output ccuIsaPkg::engineVecT beatVld,
    input  ccuIsaPkg::engineVecT collRdy
);
    import ccuIsaPkg::*;

    // Counter must hold the longest instruction
    localparam int MaxWords0 = (KnnWords > SyaWords) ? KnnWords : SyaWords;
    localparam int MaxWords  = (MaxWords0 > GicWords) ? MaxWords0 : GicWords;
    localparam int CntBits   = $clog2(MaxWords + 1);

    typedef enum logic {
        Idle,                                 // Wait for first word, grab opcode
        Steer                                 // Forward words to one collector
    } stateT;

    stateT              state;
    opcodeT             opcode;
    opcodeT             newOpcode;
    logic [CntBits-1:0] wordCnt;              // Words left, current one included
    engineT             tgtEng;
    logic               tgtKnown;
    logic               lastWord;
    logic               isaXfer;

    function automatic logic [CntBits-1:0] wordsOf(input opcodeT op);
        logic [CntBits-1:0] n;
        case (op)
            OpKnn:   n = CntBits'(KnnWords);
            OpSya:   n = CntBits'(SyaWords);
            OpGic:   n = CntBits'(GicWords);
            default: n = CntBits'(1);         // Unknown opcode is dropped alone
        endcase
        return n;
    endfunction

    assign newOpcode = opcodeT'(isaWord[OpcodeBits-1:0]);

    // ==============================
    // State, opcode and word count
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= Idle;
            opcode  <= opcodeT'({OpcodeBits{1'b0}});
            wordCnt <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (isaVld) begin
                        opcode  <= newOpcode;
                        wordCnt <= wordsOf(newOpcode);
                        state   <= Steer;
                    end
                end
                Steer: begin
                    if (isaXfer) begin
                        wordCnt <= wordCnt - 1'b1;
                        if (lastWord) begin
                            state <= Idle;    // Next fetch while configs wait
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Target engine of the captured opcode
    always_comb begin
        tgtEng   = EngKnn;
        tgtKnown = 1'b1;
        case (opcode)
            OpKnn:   tgtEng = EngKnn;
            OpSya:   tgtEng = EngSya;
            OpGic:   tgtEng = EngGic;
            default: tgtKnown = 1'b0;
        endcase
    end

    // ==============================
    // Handshakes
    // ==============================
    assign lastWord = (wordCnt == CntBits'(1));

    // Unknown words are swallowed without waiting on any collector
    assign isaRdy  = (state == Steer) && (!tgtKnown || collRdy[tgtEng]);
    assign isaXfer = isaVld && isaRdy;

    assign beat    = '{last: lastWord, word: isaWord};
    assign beatVld = (state == Steer && tgtKnown && isaVld) ?
                     engineVecT'(1) << tgtEng : '0;

endmodule

// ==== ccuCfgPkg.sv ====
/*
 * Configuration structs handed to the KNN, SYA and GIC engines.
 * Each struct is the instruction above its opcode byte, first field in the
 * low bits. Unused upper bits are reserved.
 */
package ccuCfgPkg;

    // Common field widths
    localparam int ByteBits     = 8;
    localparam int IdxBits      = 16;
    localparam int DramAddrBits = 32;

    // ==============================
    // Neighbour search (KNN)
    // ==============================
    localparam int KnnCfgBits  = 248;         // Two words minus opcode
    localparam int KnnUsedBits = 3 * IdxBits + ByteBits;

    typedef struct packed {
        logic [KnnCfgBits-KnnUsedBits-1:0] rsv;
        logic [IdxBits-1:0]                mapWrAddr;
        logic [IdxBits-1:0]                crdRdAddr;
        logic [ByteBits-1:0]               k;           // Engine takes low 6 bits
        logic [IdxBits-1:0]                nip;
    } knnCfgT;

    // ==============================
    // Systolic array (SYA)
    // ==============================
    localparam int SyaCfgBits  = 376;         // Three words minus opcode
    localparam int SyaUsedBits = 5 * ByteBits + 7 * IdxBits;

    typedef struct packed {
        logic [SyaCfgBits-SyaUsedBits-1:0] rsv;
        logic [IdxBits-1:0]                ofmWrBaseAddr;
        logic [IdxBits-1:0]                wgtRdBaseAddr;
        logic [IdxBits-1:0]                actRdBaseAddr;
        logic [ByteBits-1:0]               loopOrder;   // Bit 0 only
        logic [IdxBits-1:0]                numTilIfm;
        logic [IdxBits-1:0]                numTilFlt;
        logic [IdxBits-1:0]                numGrpPerTile;
        logic [IdxBits-1:0]                chn;
        logic [ByteBits-1:0]               zp;
        logic [ByteBits-1:0]               shift;
        logic [ByteBits-1:0]               ofmPhaseShift;  // Bit 0 only
        logic [ByteBits-1:0]               mode;        // Low 2 bits used
    } syaCfgT;

    // ==============================
    // Off-chip transfer (GIC)
    // ==============================
    localparam int GicCfgBits  = 248;
    localparam int GicUsedBits = ByteBits + DramAddrBits + 2 * IdxBits;

    // Direction codes for inOut
    localparam logic [ByteBits-1:0] GicIn2Chip = 8'd0;
    localparam logic [ByteBits-1:0] GicOut2Mem = 8'd1;

    typedef struct packed {
        logic [GicCfgBits-GicUsedBits-1:0] rsv;
        logic [IdxBits-1:0]                num;
        logic [IdxBits-1:0]                glbBaseAddr;
        logic [DramAddrBits-1:0]           dramBaseAddr;
        logic [ByteBits-1:0]               inOut;       // GicIn2Chip or GicOut2Mem
    } gicCfgT;

endpackage

// ==== ccuIsaPkg.sv ====
/*
 * Instruction stream definitions for the configuration control unit.
 * Word format, opcodes, word counts per instruction and the beat that the
 * decoder hands to the collectors. Import into module bodies.
 */
package ccuIsaPkg;

    // ==============================
    // Instruction word
    // ==============================
    localparam int WordBits   = 128;
    localparam int OpcodeBits = 8;            // Low byte of the first word

    typedef logic [WordBits-1:0] isaWordT;

    // Reference opcode values
    typedef enum logic [OpcodeBits-1:0] {
        OpKnn = 8'd2,
        OpSya = 8'd3,
        OpGic = 8'd5
    } opcodeT;

    // Words per instruction, opcode word included
    localparam int KnnWords = 2;
    localparam int SyaWords = 3;
    localparam int GicWords = 2;

    // ==============================
    // Engine steering
    // ==============================
    typedef enum logic [1:0] {
        EngKnn = 2'd0,
        EngSya = 2'd1,
        EngGic = 2'd2
    } engineT;

    localparam int NumEngines = 3;

    // One bit per engine, indexed by engineT
    typedef logic [NumEngines-1:0] engineVecT;

    // Decoder to collector transfer unit
    typedef struct packed {
        logic    last;                        // Final word of the instruction
        isaWordT word;
    } isaBeatT;

endpackage
